// File: Makefile
VERILATOR ?= verilator
TOP       ?= motorCtrlTb
FILELIST  ?= motorCtrl.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= Checks failed
PASS_MSG  ?= All checks passed

SIM     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) src/motorCtrl_macros.svh

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended early, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: motorCtrl.f
+incdir+src
src/motorPkg.sv
src/motorRegs.sv
src/commutationTimer.sv
src/pwmGenerator.sv
src/motorCtrl.sv
tb/motorCtrlTb.sv

// File: src/commutationTimer.sv
`timescale 1ns/1ns
`include "motorCtrl_macros.svh"

module commutationTimer (
    input  logic              clk,
    input  logic              nRst,
    input  motorPkg::motorCfg cfg,
    output logic              stepLast,
    output logic [2:0]        stepIdx,
    output logic [2:0]        phaseEn,
    output logic [2:0]        low
);

    logic [`MOTOR_STEP_W-1:0] stepCnt;
    logic                     running;
    logic [2:0]               idxNext;
    logic [5:0]               stepDec;

    // phases come on one cycle after enable, so the first step is as long as the rest
    assign running  = (phaseEn != 3'b000);
    assign stepLast = cfg.enable && running && (stepCnt == '0);

    always_comb begin
        idxNext = stepIdx;
        if (stepLast) begin
            if (cfg.dir) begin
                idxNext = (stepIdx == 3'd0) ? 3'd5 : stepIdx - 3'd1;
            end else begin
                idxNext = (stepIdx == 3'd5) ? 3'd0 : stepIdx + 3'd1;
            end
        end
    end

    // high side in the upper half, low side in the lower half
    always_comb begin
        case (idxNext)
            3'd0:    stepDec = 6'b001_010;
            3'd1:    stepDec = 6'b001_100;
            3'd2:    stepDec = 6'b010_100;
            3'd3:    stepDec = 6'b010_001;
            3'd4:    stepDec = 6'b100_001;
            3'd5:    stepDec = 6'b100_010;
            default: stepDec = 6'b000_000;
        endcase
    end

    always_ff @(posedge clk or negedge nRst) begin
        if (!nRst) begin
            stepCnt <= '0;
            stepIdx <= 3'd0;
            phaseEn <= 3'b000;
            low     <= 3'b000;
        end else if (!cfg.enable) begin
            stepCnt <= cfg.stepLen;  // index keeps its value while stopped
            phaseEn <= 3'b000;
            low     <= 3'b000;
        end else begin
            if (stepLast || !running) begin
                stepCnt <= cfg.stepLen;
            end else begin
                stepCnt <= stepCnt - 1'b1;
            end
            stepIdx <= idxNext;
            phaseEn <= stepDec[5:3];
            low     <= stepDec[2:0];
        end
    end

    idxInRange: assert property (
        @(posedge clk) disable iff (!nRst) stepIdx < 3'd6
    );

    // one switch per side at most, and never both switches of one leg
    noShootThrough: assert property (
        @(posedge clk) disable iff (!nRst)
        $onehot0(phaseEn) && $onehot0(low) && ((phaseEn & low) == 3'b000)
    );

endmodule

// File: src/motorCtrl.sv
`timescale 1ns/1ns

module motorCtrl (
    input  logic                  clk,
    input  logic                  nRst,
    input  motorPkg::apbReq       apbIn,
    output motorPkg::apbRsp       apbOut,
    output motorPkg::phaseDrive   drive
);

    motorPkg::motorCfg cfg;
    logic              stepLast;
    logic [2:0]        stepIdx;
    logic [2:0]        phaseEn;
    logic [2:0]        highSide;
    logic [2:0]        lowSide;

    motorRegs iRegs (
        .clk     (clk),
        .nRst    (nRst),
        .req     (apbIn),
        .rsp     (apbOut),
        .stepIdx (stepIdx),
        .cfg     (cfg)
    );

    commutationTimer iTimer (
        .clk      (clk),
        .nRst     (nRst),
        .cfg      (cfg),
        .stepLast (stepLast),
        .stepIdx  (stepIdx),
        .phaseEn  (phaseEn),
        .low      (lowSide)
    );

    pwmGenerator iPwm (
        .clk      (clk),
        .nRst     (nRst),
        .duty     (cfg.duty),
        .stepLast (stepLast),
        .phaseEn  (phaseEn),
        .high     (highSide)
    );

    assign drive = '{high: highSide, low: lowSide};

endmodule

// File: src/motorCtrl_macros.svh
`ifndef MOTORCTRL_MACROS_SVH
`define MOTORCTRL_MACROS_SVH

// APB bus widths
`define MOTOR_ADDR_W      4
`define MOTOR_DATA_W      32

`define MOTOR_DUTY_W      12
`define MOTOR_STEP_W      25

`define MOTOR_PWM_FULL    12'd4095  // duty that holds pwm high
`define MOTOR_STEP_RST    25'd1000  // step length out of reset

`define MOTOR_ADDR_CTRL   4'h0
`define MOTOR_ADDR_DUTY   4'h4
`define MOTOR_ADDR_STEP   4'h8
`define MOTOR_ADDR_STATUS 4'hc

`endif

// File: src/motorPkg.sv
`include "motorCtrl_macros.svh"

package motorPkg;

    typedef struct packed {
        logic                       psel;
        logic                       penable;
        logic                       pwrite;
        logic [`MOTOR_ADDR_W-1:0]   paddr;
        logic [`MOTOR_DATA_W-1:0]   pwdata;
    } apbReq;

    typedef struct packed {
        logic [`MOTOR_DATA_W-1:0]   prdata;
        logic                       pready;
        logic                       pslverr;
    } apbRsp;

    // register contents seen by the timer and the generator
    typedef struct packed {
        logic                       enable;
        logic                       dir;
        logic [`MOTOR_DUTY_W-1:0]   duty;
        logic [`MOTOR_STEP_W-1:0]   stepLen;
    } motorCfg;

    typedef struct packed {
        logic [2:0]                 high;  // bit 0 is phase A
        logic [2:0]                 low;
    } phaseDrive;

endpackage

// File: src/motorRegs.sv
`timescale 1ns/1ns
`include "motorCtrl_macros.svh"

module motorRegs (
    input  logic              clk,
    input  logic              nRst,
    input  motorPkg::apbReq   req,
    output motorPkg::apbRsp   rsp,
    input  logic [2:0]        stepIdx,
    output motorPkg::motorCfg cfg
);

    logic                     access;
    logic                     wrEn;
    logic                     mapped;
    logic                     slvErr;
    logic [`MOTOR_DATA_W-1:0] rdData;

    assign access = req.psel && req.penable;  // zero wait states, so this is the last cycle
    assign wrEn   = access && req.pwrite;

    assign mapped = (req.paddr == `MOTOR_ADDR_CTRL) ||
                    (req.paddr == `MOTOR_ADDR_DUTY) ||
                    (req.paddr == `MOTOR_ADDR_STEP) ||
                    (req.paddr == `MOTOR_ADDR_STATUS);

    // STATUS is read only
    assign slvErr = access && (!mapped || (req.pwrite && req.paddr == `MOTOR_ADDR_STATUS));

    always_ff @(posedge clk or negedge nRst) begin
        if (!nRst) begin
            cfg.enable  <= 1'b0;
            cfg.dir     <= 1'b0;
            cfg.duty    <= '0;
            cfg.stepLen <= `MOTOR_STEP_RST;
        end else if (wrEn) begin
            case (req.paddr)
                `MOTOR_ADDR_CTRL: begin
                    cfg.enable <= req.pwdata[0];
                    cfg.dir    <= req.pwdata[1];
                end
                `MOTOR_ADDR_DUTY: begin
                    cfg.duty <= req.pwdata[`MOTOR_DUTY_W-1:0];
                end
                `MOTOR_ADDR_STEP: begin
                    cfg.stepLen <= req.pwdata[`MOTOR_STEP_W-1:0];
                end
                default: begin
                end
            endcase
        end
    end

    always_comb begin
        rdData = '0;
        if (access && !req.pwrite) begin
            case (req.paddr)
                `MOTOR_ADDR_CTRL: begin
                    rdData = {{(`MOTOR_DATA_W-2){1'b0}}, cfg.dir, cfg.enable};
                end
                `MOTOR_ADDR_DUTY: begin
                    rdData = {{(`MOTOR_DATA_W-`MOTOR_DUTY_W){1'b0}}, cfg.duty};
                end
                `MOTOR_ADDR_STEP: begin
                    rdData = {{(`MOTOR_DATA_W-`MOTOR_STEP_W){1'b0}}, cfg.stepLen};
                end
                `MOTOR_ADDR_STATUS: begin
                    rdData = {{(`MOTOR_DATA_W-4){1'b0}}, cfg.enable, stepIdx};  // enable at bit 3
                end
                default: begin
                    rdData = '0;
                end
            endcase
        end
    end

    assign rsp.prdata  = rdData;
    assign rsp.pready  = 1'b1;
    assign rsp.pslverr = slvErr;

    // the master must open every transfer with a setup phase
    penableNeedsPsel: assert property (
        @(posedge clk) disable iff (!nRst) req.penable |-> req.psel
    );

endmodule

// File: src/pwmGenerator.sv
`timescale 1ns/1ns
`include "motorCtrl_macros.svh"

module pwmGenerator (
    input  logic                     clk,
    input  logic                     nRst,
    input  logic [`MOTOR_DUTY_W-1:0] duty,
    input  logic                     stepLast,
    input  logic [2:0]               phaseEn,
    output logic [2:0]               high
);

    logic [`MOTOR_DUTY_W-1:0] dutyQ;
    logic [`MOTOR_DUTY_W-1:0] pwmCnt;
    logic [`MOTOR_DUTY_W-1:0] offLoad;
    logic [`MOTOR_DUTY_W-1:0] onLoad;
    logic                     reload;
    logic                     cntLast;
    logic                     pwm;

    // restart the period at every commutation and while the bridge is off
    assign reload  = stepLast || (phaseEn == 3'b000);
    assign cntLast = (pwmCnt == '0);

    // counts are one less than the time spent in each level
    assign offLoad = `MOTOR_PWM_FULL - dutyQ;
    assign onLoad  = dutyQ - 1'b1;

    always_ff @(posedge clk or negedge nRst) begin
        if (!nRst) begin
            dutyQ <= '0;
        end else if (reload) begin
            dutyQ <= duty;
        end
    end

    always_ff @(posedge clk or negedge nRst) begin
        if (!nRst) begin
            pwm    <= 1'b0;
            pwmCnt <= `MOTOR_PWM_FULL;
        end else if (reload) begin
            pwm    <= 1'b0;
            pwmCnt <= `MOTOR_PWM_FULL - duty;  // off time of the duty being latched
        end else if (dutyQ == `MOTOR_PWM_FULL) begin
            pwm <= 1'b1;
        end else if (cntLast) begin
            if (pwm || dutyQ == '0) begin
                pwm    <= 1'b0;  // zero duty just keeps repeating the off time
                pwmCnt <= offLoad;
            end else begin
                pwm    <= 1'b1;
                pwmCnt <= onLoad;
            end
        end else begin
            pwmCnt <= pwmCnt - 1'b1;
        end
    end

    assign high = phaseEn & {3{pwm}};

    highOnlyWhenEnabled: assert property (
        @(posedge clk) disable iff (!nRst) (high & ~phaseEn) == 3'b000
    );

endmodule

// File: tb/motorCtrlTb.sv
`timescale 1ns/1ns
`include "motorCtrl_macros.svh"

module motorCtrlTb;

    localparam int CLK_PERIOD = 4;
    localparam int PWM_PERIOD = 4096;
    // random duty, two constant duties, duty update, both commutation runs, then the short tests
    localparam int RUN_CYCLES = 3 * PWM_PERIOD + 2 * (PWM_PERIOD + 64) + 4 * PWM_PERIOD
                                + 2 * 13 * 41 + 1000;
    localparam int TIMEOUT_NS = RUN_CYCLES * CLK_PERIOD * 3 / 2;
    localparam logic [2:0] HIGH_TAB [6] = '{3'b001, 3'b001, 3'b010, 3'b010, 3'b100, 3'b100};
    localparam logic [2:0] LOW_TAB  [6] = '{3'b010, 3'b100, 3'b100, 3'b001, 3'b001, 3'b010};

    logic                clk;
    logic                nRst;
    motorPkg::apbReq     apbIn;
    motorPkg::apbRsp     apbOut;
    motorPkg::phaseDrive drive;
    logic [31:0]         lfsrState = 32'd79981;
    int                  checks = 0;
    int                  errors = 0;

    motorCtrl i_dut (.clk(clk), .nRst(nRst), .apbIn(apbIn), .apbOut(apbOut), .drive(drive));

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic lfsrBit();
        logic lsb;
        lsb       = lfsrState[0];
        lfsrState = lfsrState >> 1;
        if (lsb) begin
            lfsrState = lfsrState ^ 32'hB4BCD35C;
        end
        return lsb;
    endfunction

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsrBit()};
        end
        return r;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            $display("Fail at %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic reportTest(input string name, input int startErrors);
        $display("%-16s finished with %0d errors", name, errors - startErrors);
    endtask

    task automatic apbWrite(input logic [3:0] addr, input logic [31:0] data, output logic err);
        int waits;
        waits = 0;
        @(posedge clk);
        apbIn <= '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: data};
        @(posedge clk);
        apbIn.penable <= 1'b1;
        @(negedge clk);
        while (!apbOut.pready && waits < 8) begin
            waits++;
            @(negedge clk);
        end
        assert (apbOut.pready) else begin
            $display("%0t ns: write to 0x%0h never completed", $time, addr);
            errors++;
        end
        err = apbOut.pslverr;
        @(posedge clk);
        apbIn <= '0;  // the register takes the data on this edge
    endtask

    task automatic apbRead(input logic [3:0] addr, output logic [31:0] data, output logic err);
        int waits;
        waits = 0;
        @(posedge clk);
        apbIn <= '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: addr, pwdata: 32'd0};
        @(posedge clk);
        apbIn.penable <= 1'b1;
        @(negedge clk);
        while (!apbOut.pready && waits < 8) begin
            waits++;
            @(negedge clk);
        end
        assert (apbOut.pready) else begin
            $display("%0t ns: read from 0x%0h never completed", $time, addr);
            errors++;
        end
        data = apbOut.prdata;
        err  = apbOut.pslverr;
        @(posedge clk);
        apbIn <= '0;
    endtask

    task automatic writeReg(input logic [3:0] addr, input logic [31:0] data);
        logic err;
        apbWrite(addr, data, err);
        checkValue("pslverr", 32'd0, 32'(err));
    endtask

    task automatic readCheck(input logic [3:0] addr, input string name, input logic [31:0] exp);
        logic [31:0] r;
        logic        err;
        apbRead(addr, r, err);
        checkValue({name, " pslverr"}, 32'd0, 32'(err));
        checkValue(name, exp, r);
    endtask

    task automatic waitPhasesOn();
        int n;
        n = 0;
        @(negedge clk);
        while (drive.low == 3'b000 && n < 16) begin
            n++;
            @(negedge clk);
        end
        checks++;
        assert (drive.low != 3'b000) else begin
            $display("%0t ns: the low-side switches never came on after enable", $time);
            errors++;
        end
    endtask

    task automatic waitPwmLevel(input logic level, input int limit);
        int n;
        n = 0;
        @(negedge clk);
        while ((|drive.high) != level && n < limit) begin
            n++;
            @(negedge clk);
        end
        checks++;
        assert ((|drive.high) == level) else begin
            $display("%0t ns: pwm did not go %s within %0d cycles", $time,
                     level ? "high" : "low", limit);
            errors++;
        end
    endtask

    // counts the cycles pwm stays at its present level, starting from this sample
    task automatic countRun(input logic level, output int n);
        n = 0;
        while ((|drive.high) == level && n < 2 * PWM_PERIOD) begin
            n++;
            @(negedge clk);
        end
    endtask

    task automatic resetState();
        int start;
        start = errors;
        checkValue("drive", 32'd0, 32'({drive.high, drive.low}));
        readCheck(`MOTOR_ADDR_CTRL, "CTRL", 32'd0);
        readCheck(`MOTOR_ADDR_DUTY, "DUTY", 32'd0);
        readCheck(`MOTOR_ADDR_STEP, "STEP", 32'd1000);
        readCheck(`MOTOR_ADDR_STATUS, "STATUS", 32'd0);
        reportTest("reset state", start);
    endtask

    task automatic registerAccess();
        logic [31:0] ctrl;
        logic [31:0] duty;
        logic [31:0] step;
        logic [31:0] r;
        logic        err;
        int          start;
        start = errors;
        ctrl = randBits(32);
        duty = randBits(32);
        step = randBits(32);
        writeReg(`MOTOR_ADDR_CTRL, ctrl);
        writeReg(`MOTOR_ADDR_DUTY, duty);
        writeReg(`MOTOR_ADDR_STEP, step);
        readCheck(`MOTOR_ADDR_CTRL, "CTRL", ctrl & 32'h3);
        readCheck(`MOTOR_ADDR_DUTY, "DUTY", duty & 32'hfff);
        readCheck(`MOTOR_ADDR_STEP, "STEP", step & 32'h1ff_ffff);
        apbWrite(`MOTOR_ADDR_STATUS, randBits(32), err);
        checkValue("pslverr on STATUS write", 32'd1, 32'(err));
        apbWrite(4'h2, randBits(32), err);
        checkValue("pslverr on unmapped write", 32'd1, 32'(err));
        apbRead(4'h6, r, err);
        checkValue("pslverr on unmapped read", 32'd1, 32'(err));
        readCheck(`MOTOR_ADDR_CTRL, "CTRL", ctrl & 32'h3);
        readCheck(`MOTOR_ADDR_DUTY, "DUTY", duty & 32'hfff);
        readCheck(`MOTOR_ADDR_STEP, "STEP", step & 32'h1ff_ffff);
        writeReg(`MOTOR_ADDR_CTRL, 32'd0);
        reportTest("register access", start);
    endtask

    task automatic disabledOutput();
        logic [5:0] seen;
        int         start;
        start = errors;
        seen  = '0;
        writeReg(`MOTOR_ADDR_CTRL, 32'h2);  // dir set, enable clear
        writeReg(`MOTOR_ADDR_DUTY, randBits(12));
        for (int i = 0; i < 200; i++) begin
            @(negedge clk);
            if ({drive.high, drive.low} != 6'b0) begin
                seen = {drive.high, drive.low};
                break;
            end
        end
        checkValue("drive", 32'd0, 32'(seen));
        reportTest("disabled output", start);
    endtask

    task automatic pulseWidth(input logic [11:0] duty);
        logic level;
        logic bad;
        int   n;
        int   start;
        start = errors;
        bad   = 1'b0;
        writeReg(`MOTOR_ADDR_CTRL, 32'd0);
        writeReg(`MOTOR_ADDR_STEP, 32'h100_0000);
        writeReg(`MOTOR_ADDR_DUTY, 32'(duty));
        writeReg(`MOTOR_ADDR_CTRL, 32'd1);
        if (duty == 12'd0 || duty == `MOTOR_PWM_FULL) begin
            level = (duty != 12'd0);
            waitPhasesOn();
            @(negedge clk);  // skip the reload cycle, which is always low
            for (int i = 0; i < PWM_PERIOD; i++) begin
                if ((|drive.high) != level) begin
                    bad = 1'b1;
                    break;
                end
                @(negedge clk);
            end
            checkValue("pwm level", 32'(level), 32'(level ^ bad));
        end else begin
            waitPwmLevel(1'b1, 2 * PWM_PERIOD);
            for (int p = 0; p < 2; p++) begin
                countRun(1'b1, n);
                checkValue("high time", 32'(duty), 32'(n));
                countRun(1'b0, n);
                checkValue("low time", 32'(PWM_PERIOD - int'(duty)), 32'(n));
            end
        end
        writeReg(`MOTOR_ADDR_CTRL, 32'd0);
        reportTest("pulse width", start);
    endtask

    task automatic commutation(input logic dir);
        logic [31:0] st;
        logic        err;
        int          idx;
        int          start;
        time         tStart;
        start = errors;
        writeReg(`MOTOR_ADDR_CTRL, 32'd0);
        writeReg(`MOTOR_ADDR_STEP, 32'd40);
        writeReg(`MOTOR_ADDR_DUTY, 32'(`MOTOR_PWM_FULL));  // pwm then drops only at step starts
        apbRead(`MOTOR_ADDR_STATUS, st, err);
        idx = int'(st[2:0]);
        writeReg(`MOTOR_ADDR_CTRL, {30'd0, dir, 1'b1});
        waitPhasesOn();
        for (int s = 0; s < 12; s++) begin
            tStart = $time;
            checkValue("drive.low", 32'(LOW_TAB[idx]), 32'(drive.low));
            checkValue("drive.high", 32'd0, 32'(drive.high));
            readCheck(`MOTOR_ADDR_STATUS, "STATUS", 32'h8 | 32'(idx));
            @(negedge clk);
            checkValue("drive.high", 32'(HIGH_TAB[idx]), 32'(drive.high));
            waitPwmLevel(1'b0, 100);
            checkValue("step length", 32'd41, 32'(($time - tStart) / CLK_PERIOD));
            idx = dir ? (idx + 5) % 6 : (idx + 1) % 6;
        end
        writeReg(`MOTOR_ADDR_CTRL, 32'd0);
        reportTest(dir ? "commutation down" : "commutation up", start);
    endtask

    task automatic dutyUpdate();
        logic [11:0] d1;
        logic [11:0] d2;
        int          n;
        int          start;
        start = errors;
        d1 = 12'((randBits(12) % 32'd4000) + 32'd1);  // leaves time for a write in the first low
        d2 = 12'((randBits(12) % 32'd4000) + 32'd1);
        if (d2 == d1) begin
            d2 = d1 + 12'd1;
        end
        writeReg(`MOTOR_ADDR_CTRL, 32'd0);
        writeReg(`MOTOR_ADDR_STEP, 32'(3 * PWM_PERIOD - 1));  // a step of exactly three periods
        writeReg(`MOTOR_ADDR_DUTY, 32'(d1));
        writeReg(`MOTOR_ADDR_CTRL, 32'd1);
        waitPhasesOn();
        writeReg(`MOTOR_ADDR_DUTY, 32'(d2));
        waitPwmLevel(1'b1, PWM_PERIOD);
        for (int p = 0; p < 4; p++) begin
            countRun(1'b1, n);
            checkValue("high time", 32'(p < 3 ? d1 : d2), 32'(n));
            if (p < 3) begin
                countRun(1'b0, n);
                checkValue("low time", 32'(PWM_PERIOD - int'(p < 2 ? d1 : d2)), 32'(n));
            end
        end
        writeReg(`MOTOR_ADDR_CTRL, 32'd0);
        reportTest("duty update", start);
    endtask

    initial begin
        logic [11:0] dRand;
        clk   = 1'b0;
        nRst  = 1'b0;
        apbIn = '0;
        repeat (5) @(posedge clk);
        nRst <= 1'b1;
        @(negedge clk);
        resetState();
        registerAccess();
        disabledOutput();
        dRand = 12'(randBits(12));
        if (dRand == 12'd0 || dRand == `MOTOR_PWM_FULL) begin
            dRand = 12'd1234;
        end
        pulseWidth(dRand);
        pulseWidth(12'd0);
        pulseWidth(`MOTOR_PWM_FULL);
        commutation(1'b0);
        commutation(1'b1);
        dutyUpdate();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
        $display("Checks failed");
        $finish;
    end

endmodule
